// ==== dv/exec_testdata.hex ====
// columns: instruction, writeback expected (1/0), rd, expected rd data, all in hex
// instructions issue in order, registers carry over from line to line
003100b3 1 01 0000000000000000 // add x1, x2, x3
123452b7 1 05 0000000012345000 // lui x5, 0x12345
67828293 1 05 0000000012345678 // addi x5, x5, 0x678
80000337 1 06 ffffffff80000000 // lui x6, 0x80000
fff00393 1 07 ffffffffffffffff // addi x7, x0, -1
80000413 1 08 fffffffffffff800 // addi x8, x0, -2048
007284b3 1 09 0000000012345677 // add x9, x5, x7
40728533 1 0a 0000000012345679 // sub x10, x5, x7
0082f5b3 1 0b 0000000012345000 // and x11, x5, x8
0062e633 1 0c ffffffff92345678 // or x12, x5, x6
0072c6b3 1 0d ffffffffedcba987 // xor x13, x5, x7
0053a733 1 0e 0000000000000001 // slt x14, x7, x5
0053b7b3 1 0f 0000000000000000 // sltu x15, x7, x5
fff32813 1 10 0000000000000001 // slti x16, x6, -1
fff2b893 1 11 0000000000000001 // sltiu x17, x5, -1
0f03f913 1 12 00000000000000f0 // andi x18, x7, 0xf0
0ab46993 1 13 fffffffffffff8ab // ori x19, x8, 0xab
fff2ca13 1 14 ffffffffedcba987 // xori x20, x5, -1
03f39a93 1 15 8000000000000000 // slli x21, x7, 63
43fadb13 1 16 ffffffffffffffff // srai x22, x21, 63
03fadb93 1 17 0000000000000001 // srli x23, x21, 63
02400c13 1 18 0000000000000024 // addi x24, x0, 36
01829cb3 1 19 2345678000000000 // sll x25, x5, x24
01835d33 1 1a 000000000fffffff // srl x26, x6, x24
405addb3 1 1b ffffffffffffff80 // sra x27, x21, x5 (shamt 56)
00128013 0 00 0000000000000000 // addi x0, x5, 1
00502023 0 00 0000000000000000 // sw x5, 0(x0)
02528eb3 0 00 0000000000000000 // mul x29, x5, x5
00500e33 1 1c 0000000012345678 // add x28, x0, x5
008e0e93 1 1d 0000000012345680 // addi x29, x28, 8
41ce8f33 1 1e 0000000000000008 // sub x30, x29, x28
01ee9fb3 1 1f 0000001234568000 // sll x31, x29, x30

// ==== project.f ====
src/rv_exec_pkg.sv
src/exec_if.sv
src/inst_decode.sv
src/int_alu.sv
src/shifter.sv
src/reg_writeback.sv
src/exec_core.sv
dv/exec_core_sva.sv
dv/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - src/rv_exec_pkg.sv
  - src/exec_if.sv
  - src/inst_decode.sv
  - src/int_alu.sv
  - src/shifter.sv
  - src/reg_writeback.sv
  - src/exec_core.sv
  - target: test
    files:
      - dv/exec_core_sva.sv
      - dv/exec_core_tb.sv

// ==== dv/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb
    import rv_exec_pkg::*;
();

    localparam int max_tests    = 64;
    localparam int fields       = 4;
    localparam int reset_cycles = 16;
    localparam int max_gap      = 2;
    localparam int margin       = 40;

    logic        inst_selfdefine;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    reg_index_t  wb_rd;
    xlen_t       wb_data;

    // four words per test in the order inst flag rd data
    logic [63:0] test_mem [0:max_tests*fields-1];
    inst_word_u  last_inst;
    integer      seed;
    int          num_tests;
    int          pending;
    int          cycles          = 0;
    int          cycle_limit     = max_tests * 4 + reset_cycles + margin;
    int          checks          = 0;
    int          value_errors    = 0;
    int          spurious_errors = 0;
    int          file_errors     = 0;

    exec_core dut_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

    initial begin
        inst_selfdefine = 1'b0;
    end

    always #2 inst_selfdefine = ~inst_selfdefine;

    always @(posedge inst_selfdefine) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles before the test list finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_wb(input reg_index_t exp_rd, input xlen_t exp_data);
        checks++;
        if (wb_valid !== 1'b1 || wb_rd !== exp_rd || wb_data !== exp_data) begin
            value_errors++;
            $display("ERROR %0t: inst %h expected x%0d = %h, got valid %b x%0d = %h",
                     $time, last_inst, exp_rd, exp_data, wb_valid, wb_rd, wb_data);
        end
    endtask

    task automatic check_no_wb();
        checks++;
        if (wb_valid !== 1'b0) begin
            spurious_errors++;
            $display("ERROR %0t: unexpected writeback x%0d = %h after inst %h",
                     $time, wb_rd, wb_data, last_inst);
        end
    endtask

    // result of the instruction issued one edge earlier or no writeback at all
    task automatic check_previous();
        int base;
        base = pending * fields;
        if (pending < 0 || test_mem[base+1][0] == 1'b0) begin
            check_no_wb();
        end else begin
            check_wb(reg_index_t'(test_mem[base+2][4:0]), xlen_t'(test_mem[base+3]));
        end
        pending = -1;
    endtask

    initial begin
        int gap;
        int assert_errors;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        last_inst  = '0;
        seed       = 10922;
        pending    = -1;
        num_tests  = 0;
        $readmemh("dv/exec_testdata.hex", test_mem);
        while (num_tests < max_tests && !$isunknown(test_mem[num_tests*fields])) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            file_errors++;
            $display("No test vectors were read from dv/exec_testdata.hex");
        end
        cycle_limit = num_tests * 4 + reset_cycles + margin;
        repeat (reset_cycles) @(negedge inst_selfdefine);
        reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            repeat (gap) begin
                @(negedge inst_selfdefine);
                check_previous();
                inst_valid = 1'b0;
            end
            @(negedge inst_selfdefine);
            check_previous();
            last_inst  = test_mem[i*fields][31:0];
            inst       = last_inst;
            inst_valid = 1'b1;
            pending    = i;
        end
        @(negedge inst_selfdefine);
        check_previous();
        inst_valid = 1'b0;
        @(negedge inst_selfdefine);
        check_previous();
        assert_errors = dut_i.sva_i.assert_failures;
        $display("%0d checks, errors: %0d value, %0d unexpected wb, %0d file, %0d assertion",
                 checks, value_errors, spurious_errors, file_errors, assert_errors);
        if (value_errors + spurious_errors + file_errors + assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dv/exec_core_sva.sv ====
`timescale 1ns/1ps

module exec_core_sva
    import rv_exec_pkg::*;
(
    input logic       inst_selfdefine,
    input logic       reset,
    input logic       inst_valid,
    input logic       wb_valid,
    input reg_index_t wb_rd
);

    // failed assertions so far
    int assert_failures = 0;

    // quiet through reset and the first edge after it
    wb_quiet_after_reset: assert property (
        @(posedge inst_selfdefine) reset |=> !wb_valid ##1 !wb_valid
    ) else begin
        assert_failures++;
        $error("wb_valid went high during reset or on the first edge after it");
    end

    // one cycle latency from the strobe
    wb_follows_valid: assert property (
        @(posedge inst_selfdefine) disable iff (reset)
        wb_valid |-> $past(inst_valid)
    ) else begin
        assert_failures++;
        $error("wb_valid high without inst_valid one cycle earlier");
    end

    wb_rd_nonzero: assert property (
        @(posedge inst_selfdefine) disable iff (reset)
        wb_valid |-> (wb_rd != '0)
    ) else begin
        assert_failures++;
        $error("writeback reported for register x0");
    end

endmodule

bind exec_core exec_core_sva sva_i (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .inst_valid      (inst_valid),
    .wb_valid        (wb_valid),
    .wb_rd           (wb_rd)
);

// ==== src/exec_core.sv ====
`timescale 1ns/1ps

module exec_core
    import rv_exec_pkg::*;
(
    input  logic        inst_selfdefine,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        wb_valid,
    output reg_index_t  wb_rd,
    output xlen_t       wb_data
);

    reg_index_t rs1;
    reg_index_t rs2;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      alu_result;
    xlen_t      shift_result;

    exec_if ex_bus ();

    inst_decode u_decode (
        .inst     (inst),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .ex       (ex_bus.decoder)
    );

    // alu and shifter run side by side on the same operands
    int_alu u_alu (
        .ex         (ex_bus.unit),
        .alu_result (alu_result)
    );

    shifter u_shifter (
        .ex           (ex_bus.unit),
        .shift_result (shift_result)
    );

    reg_writeback u_writeback (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .ex              (ex_bus.unit),
        .alu_result      (alu_result),
        .shift_result    (shift_result),
        .rs1             (rs1),
        .rs2             (rs2),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

endmodule

// ==== src/reg_writeback.sv ====
`timescale 1ns/1ps

module reg_writeback
    import rv_exec_pkg::*;
(
    input  logic       inst_selfdefine,
    input  logic       reset,
    input  logic       inst_valid,
    exec_if.unit       ex,
    input  xlen_t      alu_result,
    input  xlen_t      shift_result,
    input  reg_index_t rs1,
    input  reg_index_t rs2,
    output xlen_t      rs1_data,
    output xlen_t      rs2_data,
    output logic       wb_valid,
    output reg_index_t wb_rd,
    output xlen_t      wb_data
);

    xlen_t regs [reg_count];
    xlen_t result;
    logic  wr_en;

    always_comb begin
        case (ex.result_src)
            src_alu: begin
                result = alu_result;
            end
            src_shift: begin
                result = shift_result;
            end
            src_imm: begin
                result = ex.operand_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // x0 is never written
    assign wr_en = inst_valid && ex.rd_en && (ex.rd != '0);

    // reads see the write of the previous edge, no bypass needed
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= wr_en;
            if (wr_en) begin
                regs[ex.rd] <= result;
                wb_rd       <= ex.rd;
                wb_data     <= result;
            end
        end
    end

endmodule

// ==== src/shifter.sv ====
`timescale 1ns/1ps

module shifter
    import rv_exec_pkg::*;
(
    exec_if.unit  ex,
    output xlen_t shift_result
);

    logic [shamt_w-1:0] shamt;
    xlen_t              shl;
    xlen_t              shr;
    xlen_t              sar;

    // only the low six bits count on RV64
    assign shamt = ex.operand_b[shamt_w-1:0];

    assign shl = ex.operand_a << shamt;
    assign shr = ex.operand_a >> shamt;
    assign sar = xlen_t'($signed(ex.operand_a) >>> shamt);

    always_comb begin
        case (ex.shift_op)
            shift_ll: begin
                shift_result = shl;
            end
            shift_rl: begin
                shift_result = shr;
            end
            shift_ra: begin
                shift_result = sar;
            end
            default: begin
                shift_result = '0;
            end
        endcase
    end

endmodule

// ==== src/int_alu.sv ====
`timescale 1ns/1ps

module int_alu
    import rv_exec_pkg::*;
(
    exec_if.unit  ex,
    output xlen_t alu_result
);

    xlen_t sum;
    xlen_t diff;
    logic  lt_signed;
    logic  lt_unsigned;

    assign sum  = ex.operand_a + ex.operand_b;
    assign diff = ex.operand_a - ex.operand_b;

    // two's complement compares
    assign lt_signed   = $signed(ex.operand_a) < $signed(ex.operand_b);
    assign lt_unsigned = ex.operand_a < ex.operand_b;

    always_comb begin
        case (ex.alu_op)
            alu_add: begin
                alu_result = sum;
            end
            alu_sub: begin
                alu_result = diff;
            end
            alu_and: begin
                alu_result = ex.operand_a & ex.operand_b;
            end
            alu_or: begin
                alu_result = ex.operand_a | ex.operand_b;
            end
            alu_xor: begin
                alu_result = ex.operand_a ^ ex.operand_b;
            end
            alu_slt: begin
                alu_result = xlen_t'(lt_signed);
            end
            alu_sltu: begin
                alu_result = xlen_t'(lt_unsigned);
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

// ==== src/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode
    import rv_exec_pkg::*;
(
    input  inst_word_u inst,
    input  xlen_t      rs1_data,
    input  xlen_t      rs2_data,
    output reg_index_t rs1,
    output reg_index_t rs2,
    exec_if.decoder    ex
);

    logic  is_reg;
    logic  is_imm;
    logic  is_lui;
    logic  mod_zero;
    logic  mod_alt;
    logic  fn_ok;
    xlen_t imm_i;
    xlen_t imm_u;

    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;

    assign is_reg = (inst.r.opcode == op_reg);
    assign is_imm = (inst.i.opcode == op_imm);
    assign is_lui = (inst.u.opcode == op_lui);

    assign imm_i = {{(xlen-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_u = {{(xlen-32){inst.u.imm20[19]}}, inst.u.imm20, 12'h000};

    // upper function bits: funct7 for R-type, imm[11:6] for I-type shifts
    // (imm[5] is shamt[5] on RV64)
    always_comb begin
        if (is_reg) begin
            mod_zero = (inst.r.funct7 == 7'b0000000);
            mod_alt  = (inst.r.funct7 == 7'b0100000);
        end else begin
            mod_zero = (inst.i.imm12[11:6] == 6'b000000);
            mod_alt  = (inst.i.imm12[11:6] == 6'b010000);
        end
    end

    always_comb begin
        ex.alu_op   = alu_add;
        ex.shift_op = shift_ll;
        fn_ok       = 1'b0;
        ex.result_src = src_alu;
        case (inst.r.funct3)
            3'b000: begin
                // sub only exists in register form
                ex.alu_op = (is_reg && mod_alt) ? alu_sub : alu_add;
                fn_ok     = is_imm || mod_zero || mod_alt;
            end
            3'b001: begin
                ex.result_src = src_shift;
                ex.shift_op   = shift_ll;
                fn_ok         = mod_zero;
            end
            3'b010: begin
                ex.alu_op = alu_slt;
                fn_ok     = is_imm || mod_zero;
            end
            3'b011: begin
                ex.alu_op = alu_sltu;
                fn_ok     = is_imm || mod_zero;
            end
            3'b100: begin
                ex.alu_op = alu_xor;
                fn_ok     = is_imm || mod_zero;
            end
            3'b101: begin
                ex.result_src = src_shift;
                ex.shift_op   = mod_alt ? shift_ra : shift_rl;
                fn_ok         = mod_zero || mod_alt;
            end
            3'b110: begin
                ex.alu_op = alu_or;
                fn_ok     = is_imm || mod_zero;
            end
            default: begin
                ex.alu_op = alu_and;
                fn_ok     = is_imm || mod_zero;
            end
        endcase
        if (is_lui) begin
            ex.result_src = src_imm;
        end
    end

    assign ex.operand_a = rs1_data;
    assign ex.operand_b = is_reg ? rs2_data : (is_lui ? imm_u : imm_i);
    assign ex.rd        = inst.r.rd;
    assign ex.rd_en     = ((is_reg || is_imm) && fn_ok) || is_lui;

endmodule

// ==== src/exec_if.sv ====
`timescale 1ns/1ps

interface exec_if
    import rv_exec_pkg::*;
();

    xlen_t       operand_a;
    xlen_t       operand_b;
    alu_op_t     alu_op;
    shift_op_t   shift_op;
    result_src_t result_src;
    reg_index_t  rd;
    logic        rd_en;

    modport decoder (
        output operand_a, operand_b, alu_op, shift_op,
        output result_src, rd, rd_en
    );

    // operand_b doubles as the lui value when result_src is src_imm
    modport unit (
        input operand_a, operand_b, alu_op, shift_op,
        input result_src, rd, rd_en
    );

endinterface

// ==== src/rv_exec_pkg.sv ====
package rv_exec_pkg;

    localparam int xlen        = 64;
    localparam int reg_count   = 32;
    localparam int reg_index_w = 5;
    localparam int shamt_w     = 6;

    typedef logic [xlen-1:0]        xlen_t;
    typedef logic [reg_index_w-1:0] reg_index_t;
    typedef logic [6:0]             opcode_t;

    // major opcodes kept in this slice
    localparam opcode_t op_reg = 7'h33;
    localparam opcode_t op_imm = 7'h13;
    localparam opcode_t op_lui = 7'h37;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic [1:0] {
        shift_ll,
        shift_rl,
        shift_ra
    } shift_op_t;

    typedef enum logic [1:0] {
        src_alu,
        src_shift,
        src_imm
    } result_src_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        reg_index_t rd;
        opcode_t    opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_index_t  rs1;
        logic [2:0]  funct3;
        reg_index_t  rd;
        opcode_t     opcode;
    } itype_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_index_t  rd;
        opcode_t     opcode;
    } utype_t;

    // one instruction word, three field layouts
    typedef union packed {
        rtype_t r;
        itype_t i;
        utype_t u;
    } inst_word_u;

endpackage
